// ==== tb.f ====
+incdir+source
source/ovi_pkg.sv
source/memop_sequencer.sv
source/store_buffer.sv
source/completion_tracker.sv
source/ovi_memop_bridge.sv
dv/ovi_memop_props.sv
dv/ovi_memop_checker.sv
dv/tb_ovi_memop_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_ovi_memop_bridge
FILELIST  := tb.f
FLAGS     := --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_ovi_memop_bridge.sv ====
/* Testbench top for the bridge: runs a table of stores and loads through the
   DUT, feeds LFSR register data and prints the final counts. */
`timescale 1ns/1ps
`default_nettype none

`include "ovi_params.svh"

module tb_ovi_memop_bridge;
  import ovi_pkg::*;

  localparam int NROWS   = 8;
  localparam int TIMEOUT = 300;

  logic   clk;
  logic   reset_n;
  logic   i_issue_valid;
  sb_id_t i_issue_sb_id;
  logic   i_autogen_store;
  logic   i_autogen_load;
  logic   i_vs3_valid;
  vreg_t  i_vs3_data;
  logic   i_lq_done;
  logic   i_lq_empty;
  logic   i_memop_sync_end;
  logic   i_store_credit;
  logic   o_memop_sync_start;
  logic   o_store_valid;
  beat_t  o_store_data;
  logic   o_completed_valid;
  sb_id_t o_completed_sb_id;

  logic        test_end;
  int          test_num;
  int          exp_beats;
  int          beat_total;
  int          done_total;
  int          err_cnt;
  int          tests_ok;
  int          tests_bad;
  int          tb_errors;
  logic        timed_out;
  logic [31:0] lfsr;

  // Kind 0 store, 1 load; row 6 withholds credits across 66 registers
  int row_kind  [NROWS] = '{0, 0, 1, 0, 0, 1, 0, 0};
  int row_regs  [NROWS] = '{1, 2, 0, 4, 8, 0, 66, 1};
  int row_id    [NROWS] = '{3, 7, 12, 21, 30, 1, 9, 17};
  int row_hold  [NROWS] = '{0, 0, 0, 0, 0, 0, 1, 0};
  int row_beats [NROWS] = '{1, 1, 0, 2, 4, 0, 33, 1};

  ovi_memop_bridge DUT (.*);

  ovi_memop_checker u_checker (
    .clk                (clk),
    .reset_n            (reset_n),
    .i_issue_valid      (i_issue_valid),
    .i_issue_sb_id      (i_issue_sb_id),
    .i_autogen_store    (i_autogen_store),
    .i_lq_done          (i_lq_done),
    .i_vs3_valid        (i_vs3_valid),
    .i_vs3_data         (i_vs3_data),
    .i_memop_sync_start (o_memop_sync_start),
    .i_store_valid      (o_store_valid),
    .i_store_data       (o_store_data),
    .i_completed_valid  (o_completed_valid),
    .i_completed_sb_id  (o_completed_sb_id),
    .i_test_end         (test_end),
    .i_test_num         (test_num),
    .i_exp_beats        (exp_beats),
    .o_beat_total       (beat_total),
    .o_done_total       (done_total),
    .o_err_cnt          (err_cnt),
    .o_tests_ok         (tests_ok),
    .o_tests_bad        (tests_bad)
  );

  always #2 clk = ~clk;

  // Fibonacci taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic make_reg(output vreg_t v);
    for (int i = 0; i < `OVI_VLEN; i++) begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  task automatic step();
    @(posedge clk);
    #0.5;
  endtask

  task automatic wait_beats(input int target);
    int n;
    n = 0;
    while (!timed_out && beat_total < target) begin
      step();
      n++;
      if (n >= TIMEOUT) begin
        $display("timeout: store beats stopped at %0d of %0d", beat_total, target);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_done(input int target);
    int n;
    n = 0;
    while (!timed_out && done_total < target) begin
      step();
      n++;
      if (n >= TIMEOUT) begin
        $display("timeout: completion never arrived after sync end and lq empty");
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic return_credits(input int count);
    for (int i = 0; i < count; i++) begin
      i_store_credit = 1'b1;
      step();
    end
    i_store_credit = 1'b0;
  endtask

  task automatic finish_seq(input int base_done);
    // Completion must wait for sync end and an empty load queue
    if (done_total != base_done) begin
      $display("error at %0t: completion before sync end and lq empty", $time);
      tb_errors++;
    end
    i_memop_sync_end = 1'b1;
    step();
    i_memop_sync_end = 1'b0;
    i_lq_empty = 1'b1;
    step();
    i_lq_empty = 1'b0;
  endtask

  task automatic run_row(input int r);
    int    base_beats;
    int    base_done;
    vreg_t v;
    base_beats = beat_total;
    base_done  = done_total;
    i_issue_valid = 1'b1;
    i_issue_sb_id = sb_id_t'(row_id[r]);
    step();
    i_issue_valid = 1'b0;
    if (row_kind[r] == 1) begin
      i_autogen_load = 1'b1;
      step();
      i_autogen_load = 1'b0;
      step();
    end else if (row_regs[r] == 1) begin
      make_reg(v);
      i_autogen_store = 1'b1;
      i_vs3_valid     = 1'b1;
      i_vs3_data      = v;
      i_lq_done       = 1'b1;
      step();
      i_autogen_store = 1'b0;
      i_vs3_valid     = 1'b0;
      i_lq_done       = 1'b0;
    end else begin
      i_autogen_store = 1'b1;
      step();
      i_autogen_store = 1'b0;
      for (int i = 0; i < row_regs[r]; i++) begin
        make_reg(v);
        i_vs3_valid = 1'b1;
        i_vs3_data  = v;
        i_lq_done   = (i == row_regs[r] - 1);
        step();
      end
      i_vs3_valid = 1'b0;
      i_lq_done   = 1'b0;
    end
    if (row_hold[r] != 0) begin
      wait_beats(base_beats + `OVI_STORE_CREDITS);
      repeat (8) step();
      if (beat_total != base_beats + `OVI_STORE_CREDITS) begin
        $display("error at %0t: beat sent with no store credits left", $time);
        tb_errors++;
      end
      // Sequence ends with the last pair still stalled in the buffer
      finish_seq(base_done);
      wait_done(base_done + 1);
      return_credits(1);
      wait_beats(base_beats + row_beats[r]);
      return_credits(row_beats[r] - 1);
    end else begin
      wait_beats(base_beats + row_beats[r]);
      finish_seq(base_done);
      wait_done(base_done + 1);
      return_credits(row_beats[r]);
    end
    step();
    test_num  = r;
    exp_beats = row_beats[r];
    test_end  = 1'b1;
    step();
    test_end  = 1'b0;
  endtask

  initial begin
    clk              = 1'b0;
    reset_n          = 1'b0;
    i_issue_valid    = 1'b0;
    i_issue_sb_id    = '0;
    i_autogen_store  = 1'b0;
    i_autogen_load   = 1'b0;
    i_vs3_valid      = 1'b0;
    i_vs3_data       = '0;
    i_lq_done        = 1'b0;
    i_lq_empty       = 1'b0;
    i_memop_sync_end = 1'b0;
    i_store_credit   = 1'b0;
    test_end         = 1'b0;
    test_num         = 0;
    exp_beats        = 0;
    tb_errors        = 0;
    timed_out        = 1'b0;
    lfsr             = 32'hea0d;
    repeat (4) @(posedge clk);
    #0.5;
    reset_n = 1'b1;
    step();
    for (int r = 0; r < NROWS; r++) begin
      if (!timed_out) run_row(r);
    end
    repeat (4) step();
    $display("tests passed %0d, failed %0d, checker errors %0d, testbench errors %0d",
             tests_ok, tests_bad, err_cnt, tb_errors);
    if (timed_out || tests_bad != 0 || err_cnt != 0 || tb_errors != 0 ||
        tests_ok != NROWS) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/ovi_memop_checker.sv ====
/* Monitor for the bridge testbench: models expected beats and completion ids
   from the DUT pins, compares them and prints one line per finished test. */
`timescale 1ns/1ps
`default_nettype none

`include "ovi_params.svh"

module ovi_memop_checker (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            i_issue_valid,
  input  ovi_pkg::sb_id_t i_issue_sb_id,
  input  logic            i_autogen_store,
  input  logic            i_lq_done,
  input  logic            i_vs3_valid,
  input  ovi_pkg::vreg_t  i_vs3_data,
  input  logic            i_memop_sync_start,
  input  logic            i_store_valid,
  input  ovi_pkg::beat_t  i_store_data,
  input  logic            i_completed_valid,
  input  ovi_pkg::sb_id_t i_completed_sb_id,
  input  logic            i_test_end,
  input  int              i_test_num,
  input  int              i_exp_beats,
  output int              o_beat_total,
  output int              o_done_total,
  output int              o_err_cnt,
  output int              o_tests_ok,
  output int              o_tests_bad
);
  import ovi_pkg::*;

  beat_t  exp_beats [$];
  sb_id_t exp_ids [$];
  vreg_t  low_reg;
  logic   have_low;
  int     beats_in;
  int     syncs_in;
  int     dones_in;
  int     errs_in;

  initial begin
    o_beat_total = 0;
    o_done_total = 0;
    o_err_cnt    = 0;
    o_tests_ok   = 0;
    o_tests_bad  = 0;
    have_low     = 1'b0;
    beats_in     = 0;
    syncs_in     = 0;
    dones_in     = 0;
    errs_in      = 0;
  end

  always @(posedge clk) begin
    beat_t  exp_b;
    sb_id_t exp_id;
    if (reset_n) begin
      if (i_issue_valid) exp_ids.push_back(i_issue_sb_id);
      // A lone register in the start cycle leaves with a zero upper half
      if (i_vs3_valid && i_autogen_store && i_lq_done) begin
        exp_beats.push_back({{`OVI_VLEN{1'b0}}, i_vs3_data});
      end else if (i_vs3_valid && !have_low) begin
        low_reg  = i_vs3_data;
        have_low = 1'b1;
      end else if (i_vs3_valid) begin
        exp_beats.push_back({i_vs3_data, low_reg});
        have_low = 1'b0;
      end
      if (i_memop_sync_start) syncs_in++;
      if (i_store_valid) begin
        beats_in++;
        o_beat_total++;
        if (exp_beats.size() == 0) begin
          $display("error at %0t: store beat with none expected", $time);
          errs_in++;
        end else begin
          exp_b = exp_beats.pop_front();
          if (i_store_data !== exp_b) begin
            $display("error at %0t: beat %0d data %h, expected %h", $time,
                     beats_in, i_store_data, exp_b);
            errs_in++;
          end
        end
      end
      if (i_completed_valid) begin
        dones_in++;
        o_done_total++;
        if (exp_ids.size() == 0) begin
          $display("error at %0t: completion with no id queued", $time);
          errs_in++;
        end else begin
          exp_id = exp_ids.pop_front();
          if (i_completed_sb_id !== exp_id) begin
            $display("error at %0t: completed id %0d, expected %0d", $time,
                     i_completed_sb_id, exp_id);
            errs_in++;
          end
        end
      end
      if (i_test_end) begin
        if (beats_in != i_exp_beats || syncs_in != 1 || dones_in != 1) begin
          $display("error at %0t: test %0d saw %0d beats, %0d sync starts, %0d completions",
                   $time, i_test_num, beats_in, syncs_in, dones_in);
          errs_in++;
        end
        $display("test %0d: %s, %0d beats, %0d errors", i_test_num,
                 (errs_in == 0) ? "ok" : "mismatch", beats_in, errs_in);
        if (errs_in == 0) o_tests_ok++;
        else o_tests_bad++;
        o_err_cnt = o_err_cnt + errs_in;
        beats_in  = 0;
        syncs_in  = 0;
        dones_in  = 0;
        errs_in   = 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/ovi_memop_props.sv ====
/* Sequencer timing assertions, bound into every memop_sequencer instance. */
`timescale 1ns/1ps
`default_nettype none

`include "ovi_params.svh"

module ovi_memop_props (
  input logic                                     clk,
  input logic                                     reset_n,
  input logic                                     st_start,
  input logic                                     ld_start,
  input logic                                     o_memop_sync_start,
  input logic [$clog2(`OVI_STORE_CREDITS):0]      credit_cnt
);

  // Sync start is a single-cycle pulse
  a_sync_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    o_memop_sync_start |=> !o_memop_sync_start)
    else $error("sync start held longer than one cycle");

  a_sync_after_start: assert property (@(posedge clk) disable iff (!reset_n)
    (st_start || ld_start) |=> o_memop_sync_start)
    else $error("sync start missing after a start pulse");

  a_credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
    credit_cnt <= `OVI_STORE_CREDITS)
    else $error("store credits above the initial grant");

endmodule

bind memop_sequencer ovi_memop_props u_props (
  .clk                (clk),
  .reset_n            (reset_n),
  .st_start           (st_start),
  .ld_start           (ld_start),
  .o_memop_sync_start (o_memop_sync_start),
  .credit_cnt         (credit_cnt)
);

`default_nettype wire

// ==== source/ovi_memop_bridge.sv ====
/* Top of the OVI memory-operation bridge: sequencer, store buffer and
   completion tracker wired to the vector unit and memory side pins. */
`timescale 1ns/1ps
`default_nettype none

module ovi_memop_bridge (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            i_issue_valid,
  input  ovi_pkg::sb_id_t i_issue_sb_id,
  input  logic            i_autogen_store,
  input  logic            i_autogen_load,
  input  logic            i_vs3_valid,
  input  ovi_pkg::vreg_t  i_vs3_data,
  input  logic            i_lq_done,
  input  logic            i_lq_empty,
  input  logic            i_memop_sync_end,
  input  logic            i_store_credit,
  output logic            o_memop_sync_start,
  output logic            o_store_valid,
  output ovi_pkg::beat_t  o_store_data,
  output logic            o_completed_valid,
  output ovi_pkg::sb_id_t o_completed_sb_id
);
  import ovi_pkg::*;

  logic buf_write;
  logic buf_clear;
  logic send_pair;
  logic send_bypass;
  logic pair_ready;
  logic commit;

  memop_sequencer u_sequencer (
    .clk                (clk),
    .reset_n            (reset_n),
    .i_autogen_store    (i_autogen_store),
    .i_autogen_load     (i_autogen_load),
    .i_lq_done          (i_lq_done),
    .i_vs3_valid        (i_vs3_valid),
    .i_memop_sync_end   (i_memop_sync_end),
    .i_lq_empty         (i_lq_empty),
    .i_store_credit     (i_store_credit),
    .i_pair_ready       (pair_ready),
    .o_buf_write        (buf_write),
    .o_buf_clear        (buf_clear),
    .o_send_pair        (send_pair),
    .o_send_bypass      (send_bypass),
    .o_commit           (commit),
    .o_memop_sync_start (o_memop_sync_start)
  );

  store_buffer u_store_buffer (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_write       (buf_write),
    .i_clear       (buf_clear),
    .i_send_pair   (send_pair),
    .i_send_bypass (send_bypass),
    .i_vs3_data    (i_vs3_data),
    .o_pair_ready  (pair_ready),
    .o_store_valid (o_store_valid),
    .o_store_data  (o_store_data)
  );

  completion_tracker u_completion (
    .clk               (clk),
    .reset_n           (reset_n),
    .i_issue_valid     (i_issue_valid),
    .i_issue_sb_id     (i_issue_sb_id),
    .i_commit          (commit),
    .o_completed_valid (o_completed_valid),
    .o_completed_sb_id (o_completed_sb_id)
  );

endmodule

`default_nettype wire

// ==== source/completion_tracker.sv ====
/* In-order scoreboard id queue; one id is returned per commit pulse on the
   registered completion outputs. */
`timescale 1ns/1ps
`default_nettype none

`include "ovi_params.svh"

module completion_tracker (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            i_issue_valid,
  input  ovi_pkg::sb_id_t i_issue_sb_id,
  input  logic            i_commit,
  output logic            o_completed_valid,
  output ovi_pkg::sb_id_t o_completed_sb_id
);
  import ovi_pkg::*;

  localparam int QPTR_W = $clog2(`OVI_SBID_DEPTH);

  sb_id_t id_queue [`OVI_SBID_DEPTH];

  logic [QPTR_W-1:0] q_wptr;
  logic [QPTR_W-1:0] q_rptr;

  // Issue never runs more than a queue ahead of completion
  always_ff @(posedge clk) begin
    if (i_issue_valid) begin
      id_queue[q_wptr] <= i_issue_sb_id;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      q_wptr <= '0;
      q_rptr <= '0;
    end else begin
      if (i_issue_valid) q_wptr <= q_wptr + 1'b1;
      if (i_commit)      q_rptr <= q_rptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      o_completed_valid <= 1'b0;
    end else begin
      o_completed_valid <= i_commit;
    end
  end

  // Oldest id, meaningful while o_completed_valid is high
  always_ff @(posedge clk) begin
    o_completed_sb_id <= id_queue[q_rptr];
  end

endmodule

`default_nettype wire

// ==== source/store_buffer.sv ====
/* Eight-entry vector register buffer that pairs registers into 512-bit
   store beats, plus the single-register bypass beat. */
`timescale 1ns/1ps
`default_nettype none

`include "ovi_params.svh"

module store_buffer (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           i_write,
  input  logic           i_clear,
  input  logic           i_send_pair,
  input  logic           i_send_bypass,
  input  ovi_pkg::vreg_t i_vs3_data,
  output logic           o_pair_ready,
  output logic           o_store_valid,
  output ovi_pkg::beat_t o_store_data
);
  import ovi_pkg::*;

  localparam int PTR_W = $clog2(`OVI_STORE_DEPTH);

  vreg_t entry [`OVI_STORE_DEPTH];

  logic [`OVI_STORE_DEPTH-1:0] valid;
  logic [`OVI_STORE_DEPTH-1:0] sent;
  logic [PTR_W-1:0]            wptr;
  logic [PTR_W-1:0]            rptr;
  logic [PTR_W-1:0]            rptr_hi;

  // Upper register of the pair, wraps with the pointer
  assign rptr_hi = rptr + 1'b1;

  assign o_pair_ready = valid[rptr] && !sent[rptr] &&
                        valid[rptr_hi] && !sent[rptr_hi];

  always_ff @(posedge clk) begin
    if (i_write) begin
      entry[wptr] <= i_vs3_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid <= '0;
      sent  <= '0;
      wptr  <= '0;
      rptr  <= '0;
    end else if (i_clear) begin
      valid <= '0;
      sent  <= '0;
      wptr  <= '0;
      rptr  <= '0;
    end else begin
      if (i_send_pair) begin
        sent[rptr]    <= 1'b1;
        sent[rptr_hi] <= 1'b1;
        rptr          <= rptr + 2'd2;
      end
      // A new write reopens its slot
      if (i_write) begin
        valid[wptr] <= 1'b1;
        sent[wptr]  <= 1'b0;
        wptr        <= wptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      o_store_valid <= 1'b0;
    end else begin
      o_store_valid <= i_send_pair || i_send_bypass;
    end
  end

  // Little endian, lower register in bits 255 to 0
  always_ff @(posedge clk) begin
    if (i_send_bypass) begin
      o_store_data <= {{`OVI_VLEN{1'b0}}, i_vs3_data};
    end else if (i_send_pair) begin
      o_store_data <= {entry[rptr_hi], entry[rptr]};
    end
  end

endmodule

`default_nettype wire

// ==== source/memop_sequencer.sv ====
/* Store and load sequencing for the bridge: decides buffer writes, beat sends,
   store credits, the memory sync start pulse and the commit pulse. */
`timescale 1ns/1ps
`default_nettype none

`include "ovi_params.svh"

module memop_sequencer (
  input  logic clk,
  input  logic reset_n,
  input  logic i_autogen_store,
  input  logic i_autogen_load,
  input  logic i_lq_done,
  input  logic i_vs3_valid,
  input  logic i_memop_sync_end,
  input  logic i_lq_empty,
  input  logic i_store_credit,
  input  logic i_pair_ready,
  output logic o_buf_write,
  output logic o_buf_clear,
  output logic o_send_pair,
  output logic o_send_bypass,
  output logic o_commit,
  output logic o_memop_sync_start
);
  import ovi_pkg::*;

  localparam int CREDIT_W = $clog2(`OVI_STORE_CREDITS) + 1;

  store_state_t st_state;
  store_state_t st_next;
  load_state_t  ld_state;
  load_state_t  ld_next;

  logic [CREDIT_W-1:0] credit_cnt;
  logic                st_start;
  logic                ld_start;
  logic                beat_sent;
  logic                st_commit_q;
  logic                ld_commit;

  assign st_start = (st_state == ST_IDLE) && i_autogen_store;
  assign ld_start = (ld_state == LD_IDLE) && i_autogen_load;

  always_comb begin
    st_next = st_state;
    case (st_state)
      ST_IDLE: begin
        if (i_autogen_store) begin
          st_next = i_lq_done ? ST_WAIT_SYNC : ST_COLLECT;
        end
      end
      ST_COLLECT: begin
        if (i_lq_done) st_next = ST_WAIT_SYNC;
      end
      ST_WAIT_SYNC: begin
        if (i_memop_sync_end) st_next = ST_DRAIN;
      end
      ST_DRAIN: begin
        if (i_lq_empty) st_next = ST_IDLE;
      end
      default: st_next = ST_IDLE;
    endcase
  end

  always_comb begin
    ld_next = ld_state;
    case (ld_state)
      LD_IDLE: begin
        if (i_autogen_load) ld_next = LD_WAIT_SYNC;
      end
      LD_WAIT_SYNC: begin
        if (i_memop_sync_end) ld_next = LD_DRAIN;
      end
      LD_DRAIN: begin
        if (i_lq_empty) ld_next = LD_IDLE;
      end
      default: ld_next = LD_IDLE;
    endcase
  end

  // Single register goes straight out, only possible in the start cycle
  assign o_send_bypass = st_start && i_lq_done && i_vs3_valid;

  assign o_buf_write = i_vs3_valid && !o_send_bypass &&
                       ((st_state == ST_COLLECT) || st_start);

  // Stalled pairs keep draining after the sequence ends, so no state term here
  assign o_send_pair = i_pair_ready && (credit_cnt != '0);

  // Leave the buffer alone while pairs are still waiting for credits
  assign o_buf_clear = (st_state == ST_IDLE) && (ld_state == LD_IDLE) &&
                       !i_autogen_store && !i_autogen_load && !i_pair_ready;

  assign beat_sent = o_send_pair || o_send_bypass;

  assign ld_commit = (ld_state == LD_DRAIN) && i_lq_empty;
  assign o_commit  = st_commit_q || ld_commit;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      st_state           <= ST_IDLE;
      ld_state           <= LD_IDLE;
      credit_cnt         <= CREDIT_W'(`OVI_STORE_CREDITS);
      st_commit_q        <= 1'b0;
      o_memop_sync_start <= 1'b0;
    end else begin
      st_state           <= st_next;
      ld_state           <= ld_next;
      st_commit_q        <= (st_state == ST_DRAIN) && i_lq_empty;
      o_memop_sync_start <= st_start || ld_start;
      if (beat_sent && !i_store_credit) begin
        credit_cnt <= credit_cnt - 1'b1;
      end else if (i_store_credit && !beat_sent) begin
        credit_cnt <= credit_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/ovi_pkg.sv ====
/* Types shared by the bridge RTL and the testbench checker. */
`default_nettype none

`include "ovi_params.svh"

package ovi_pkg;

  typedef logic [`OVI_VLEN-1:0] vreg_t;

  typedef logic [`OVI_BEAT_W-1:0] beat_t;

  typedef logic [`OVI_SB_ID_W-1:0] sb_id_t;

  // Store sequence: collect registers, wait for memory sync, then drain
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COLLECT,
    ST_WAIT_SYNC,
    ST_DRAIN
  } store_state_t;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_WAIT_SYNC,
    LD_DRAIN
  } load_state_t;

endpackage

`default_nettype wire

// ==== source/ovi_params.svh ====
/* Sizes shared by the OVI memory-operation bridge and its testbench.
   Include wherever a width, depth or credit count is needed. */
`ifndef OVI_PARAMS_SVH
`define OVI_PARAMS_SVH

// One vector register
`define OVI_VLEN 256

// Store beat carries two registers, lower register in the low half
`define OVI_BEAT_W 512

// Store buffer entries
`define OVI_STORE_DEPTH 8

// Store credits granted out of reset
`define OVI_STORE_CREDITS 32

// Scoreboard id width
`define OVI_SB_ID_W 5

// Outstanding scoreboard ids held for completion
`define OVI_SBID_DEPTH 8

`endif
